//--- dcache_array.f
hdl/dcache_pkg.sv
hdl/dcache_port_arbiter.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_array.sv
verification/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache_array

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_port_arbiter.sv
  - hdl/dcache_tag_array.sv
  - hdl/dcache_data_array.sv
  - hdl/dcache_array.sv
  - target: test
    files:
      - verification/dcache_tb.sv

//--- verification/dcache_tb.sv
module dcache_tb import dcache_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PORTS           = 4;
  localparam int WAYS            = 2;
  localparam int SETS            = 2 ** INDEX_W;
  localparam int PERIOD          = 20;
  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 16;
  localparam int NUM_RANDOM      = 2000;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_update_valid;
  logic [0:0]            i_update_way;
  logic [PADDR_W-1:0]    i_update_paddr;
  logic [LINE_BYTES-1:0] i_update_be;
  logic [LINE_W-1:0]     i_update_data;
  logic [PORTS-1:0]      i_rd_valid;
  logic [PORTS-1:0]      i_rd_h_pri;
  logic [PADDR_W-1:0]    i_rd_paddr [PORTS];
  logic [PORTS-1:0]      o_rd_hit;
  logic [PORTS-1:0]      o_rd_miss;
  logic [PORTS-1:0]      o_rd_conflict;
  logic [LINE_W-1:0]     o_rd_data [PORTS];

  // reference model state
  logic [TAG_W-1:0]      model_tag   [WAYS][SETS];
  logic                  model_valid [WAYS][SETS];
  logic [LINE_W-1:0]     model_line  [WAYS][SETS];
  logic [PORTS-1:0]      exp_hit;
  logic [PORTS-1:0]      exp_miss;
  logic [PORTS-1:0]      exp_conflict;
  logic [LINE_W-1:0]     exp_data [PORTS];

  logic [31:0]           seed = 32'd92;

  dcache_array i_dcache_array (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_update_valid(i_update_valid),
    .i_update_way  (i_update_way),
    .i_update_paddr(i_update_paddr),
    .i_update_be   (i_update_be),
    .i_update_data (i_update_data),
    .i_rd_valid    (i_rd_valid),
    .i_rd_h_pri    (i_rd_h_pri),
    .i_rd_paddr    (i_rd_paddr),
    .o_rd_hit      (o_rd_hit),
    .o_rd_miss     (o_rd_miss),
    .o_rd_conflict (o_rd_conflict),
    .o_rd_data     (o_rd_data)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [PADDR_W-1:0] make_paddr(
    input logic [TAG_W-1:0]    tag,
    input logic [INDEX_W-1:0]  idx,
    input logic [OFFSET_W-1:0] off
  );
    return {tag, idx, off};
  endfunction

  function automatic logic [TAG_W-1:0] pool_tag(input logic [1:0] sel);
    case (sel)
      2'd0:    return 22'h1a2b3;
      2'd1:    return 22'h00007;
      2'd2:    return 22'h3fffe;
      default: return 22'h15555;
    endcase
  endfunction

  function automatic logic [INDEX_W-1:0] pool_index(input logic [1:0] sel);
    case (sel)
      2'd0:    return 6'd3;
      2'd1:    return 6'd17;
      2'd2:    return 6'd42;
      default: return 6'd63;
    endcase
  endfunction

  function automatic logic [INDEX_W-1:0] index_of(input logic [PADDR_W-1:0] paddr);
    return paddr[OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [TAG_W-1:0] tag_of(input logic [PADDR_W-1:0] paddr);
    return paddr[PADDR_W-1 -: TAG_W];
  endfunction

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic clear_inputs();
    i_update_valid = 1'b0;
    i_update_way   = '0;
    i_update_paddr = '0;
    i_update_be    = '0;
    i_update_data  = '0;
    i_rd_valid     = '0;
    i_rd_h_pri     = '0;
    for (int p = 0; p < PORTS; p++) begin
      i_rd_paddr[p] = '0;
    end
  endtask

  task automatic set_update(
    input logic [0:0]            way,
    input logic [PADDR_W-1:0]    paddr,
    input logic [LINE_BYTES-1:0] be
  );
    i_update_valid = 1'b1;
    i_update_way   = way;
    i_update_paddr = paddr;
    i_update_be    = be;
    i_update_data  = {next_rand(), next_rand(), next_rand(), next_rand()};
  endtask

  task automatic set_read(input int p, input logic h_pri, input logic [PADDR_W-1:0] paddr);
    i_rd_valid[p] = 1'b1;
    i_rd_h_pri[p] = h_pri;
    i_rd_paddr[p] = paddr;
  endtask

  // predict next-cycle responses, then apply the update
  always @(posedge i_clk or negedge i_reset_n) begin : model
    int                 grant;
    logic [INDEX_W-1:0] set_idx;
    logic [INDEX_W-1:0] upd_idx;
    logic [PORTS-1:0]   hit;
    logic [PORTS-1:0]   miss;
    logic [PORTS-1:0]   conflict;
    logic [LINE_W-1:0]  line [PORTS];
    if (!i_reset_n) begin
      exp_hit      <= '0;
      exp_miss     <= '0;
      exp_conflict <= '0;
      for (int w = 0; w < WAYS; w++) begin
        for (int s = 0; s < SETS; s++) begin
          model_valid[w][s] = 1'b0;
        end
      end
    end else begin
      grant    = -1;
      hit      = '0;
      miss     = '0;
      conflict = '0;
      for (int p = 0; p < PORTS; p++) begin
        if (grant < 0 && i_rd_valid[p] && i_rd_h_pri[p]) begin
          grant = p;
        end
      end
      for (int p = 0; p < PORTS; p++) begin
        if (grant < 0 && i_rd_valid[p]) begin
          grant = p;
        end
      end
      set_idx = (grant >= 0) ? index_of(i_rd_paddr[grant]) : '0;
      for (int p = 0; p < PORTS; p++) begin
        line[p] = '0;
        if (i_rd_valid[p]) begin
          if (i_update_valid || (p != grant && index_of(i_rd_paddr[p]) != set_idx)) begin
            conflict[p] = 1'b1;
          end else begin
            for (int w = 0; w < WAYS; w++) begin
              if (model_valid[w][set_idx] &&
                  model_tag[w][set_idx] == tag_of(i_rd_paddr[p])) begin
                hit[p]  = 1'b1;
                line[p] = model_line[w][set_idx];
              end
            end
            miss[p] = !hit[p];
          end
        end
      end
      exp_hit      <= hit;
      exp_miss     <= miss;
      exp_conflict <= conflict;
      for (int p = 0; p < PORTS; p++) begin
        exp_data[p] <= line[p];
      end
      if (i_update_valid) begin
        upd_idx = index_of(i_update_paddr);
        model_valid[i_update_way][upd_idx] = 1'b1;
        model_tag[i_update_way][upd_idx]   = tag_of(i_update_paddr);
        for (int b = 0; b < LINE_BYTES; b++) begin
          if (i_update_be[b]) begin
            model_line[i_update_way][upd_idx][b*8 +: 8] = i_update_data[b*8 +: 8];
          end
        end
      end
    end
  end

  a_hit: assert property (@(posedge i_clk) disable iff (!i_reset_n) o_rd_hit == exp_hit)
    else begin
      $display("Fail time %0t o_rd_hit expected %b actual %b",
               $time, $sampled(exp_hit), $sampled(o_rd_hit));
      stop_with_failure();
    end

  a_miss: assert property (@(posedge i_clk) disable iff (!i_reset_n) o_rd_miss == exp_miss)
    else begin
      $display("Fail time %0t o_rd_miss expected %b actual %b",
               $time, $sampled(exp_miss), $sampled(o_rd_miss));
      stop_with_failure();
    end

  a_conflict: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) o_rd_conflict == exp_conflict
  ) else begin
      $display("Fail time %0t o_rd_conflict expected %b actual %b",
               $time, $sampled(exp_conflict), $sampled(o_rd_conflict));
      stop_with_failure();
    end

  for (genvar p = 0; p < PORTS; p++) begin : g_data_chk
    a_data: assert property (
      @(posedge i_clk) disable iff (!i_reset_n) exp_hit[p] |-> o_rd_data[p] == exp_data[p]
    ) else begin
        $display("Fail time %0t o_rd_data[%0d] expected %h actual %h",
                 $time, p, $sampled(exp_data[p]), $sampled(o_rd_data[p]));
        stop_with_failure();
      end
  end

  initial begin
    i_clk = 1'b0;
    forever #(PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #((RESET_CYCLES + DIRECTED_CYCLES + NUM_RANDOM + 50) * PERIOD);
    $display("Timeout: the test sequence did not complete in time");
    stop_with_failure();
  end

  initial begin
    logic [PADDR_W-1:0] addr_a;
    logic [PADDR_W-1:0] addr_b;
    logic [PADDR_W-1:0] addr_c;
    logic [PADDR_W-1:0] addr;
    logic [31:0]        r;
    logic [31:0]        r2;
    logic [0:0]         way;
    i_reset_n = 1'b0;
    clear_inputs();
    addr_a = make_paddr(pool_tag(2'd0), pool_index(2'd0), 4'h0);
    addr_b = make_paddr(pool_tag(2'd1), pool_index(2'd0), 4'h8);
    addr_c = make_paddr(pool_tag(2'd2), pool_index(2'd1), 4'h4);
    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    // cold cache so every read misses or conflicts
    @(negedge i_clk);
    set_read(0, 1'b0, addr_a);
    set_read(1, 1'b0, addr_b);
    set_read(2, 1'b0, addr_c);
    set_read(3, 1'b0, addr_a);
    @(negedge i_clk);
    clear_inputs();
    set_update(1'b0, addr_a, '1);
    @(negedge i_clk);
    clear_inputs();
    set_read(0, 1'b0, addr_a);
    // partial write merges with older bytes
    @(negedge i_clk);
    clear_inputs();
    set_update(1'b0, addr_a, 16'h00f0);
    @(negedge i_clk);
    clear_inputs();
    set_read(1, 1'b0, addr_a);
    // second way of the same set
    @(negedge i_clk);
    clear_inputs();
    set_update(1'b1, addr_b, '1);
    @(negedge i_clk);
    clear_inputs();
    set_read(0, 1'b0, addr_a);
    set_read(2, 1'b0, addr_b);
    @(negedge i_clk);
    clear_inputs();
    set_update(1'b0, addr_c, '1);
    // high priority port 2 wins and port 1 shares its set
    @(negedge i_clk);
    clear_inputs();
    set_read(0, 1'b0, addr_c);
    set_read(1, 1'b0, addr_a);
    set_read(2, 1'b1, addr_b);
    set_read(3, 1'b1, addr_c);
    @(negedge i_clk);
    clear_inputs();
    set_read(1, 1'b0, addr_c);
    set_read(3, 1'b0, addr_a);
    // update steals the cycle from all readers
    @(negedge i_clk);
    clear_inputs();
    set_update(1'b1, make_paddr(pool_tag(2'd3), pool_index(2'd2), 4'h0), '1);
    for (int p = 0; p < PORTS; p++) begin
      set_read(p, 1'b0, addr_a);
    end

    repeat (NUM_RANDOM) begin
      @(negedge i_clk);
      clear_inputs();
      r  = next_rand();
      r2 = next_rand();
      if (r[31:30] == 2'b00) begin
        addr = make_paddr(pool_tag(r[29:28]), pool_index(r[27:26]), r[25:22]);
        way  = r[21];
        // keep one tag in at most one way of a set
        if (model_valid[~way][index_of(addr)] && model_tag[~way][index_of(addr)] == tag_of(addr))
          way = ~way;
        set_update(way, addr, model_valid[way][index_of(addr)] ? r2[31:16] : '1);
      end
      for (int p = 0; p < PORTS; p++) begin
        r = next_rand();
        if (r[31:29] < 3'd5) begin
          set_read(p, r[28:27] == 2'b00,
                   make_paddr(pool_tag(r[26:25]), pool_index(r[24:23]), r[22:19]));
        end else begin
          // priority on an idle port must not take the grant
          i_rd_h_pri[p] = r[28];
        end
      end
    end

    @(negedge i_clk);
    clear_inputs();
    repeat (3) @(posedge i_clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- hdl/dcache_array.sv
module dcache_array import dcache_pkg::*; #(
  parameter  int READ_PORT_NUM = 4,
  parameter  int WAYS          = 2,
  localparam int WAY_W         = (WAYS > 1) ? $clog2(WAYS) : 1
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_update_valid,
  input  logic [WAY_W-1:0]         i_update_way,
  input  logic [PADDR_W-1:0]       i_update_paddr,
  input  logic [LINE_BYTES-1:0]    i_update_be,
  input  logic [LINE_W-1:0]        i_update_data,

  input  logic [READ_PORT_NUM-1:0] i_rd_valid,
  input  logic [READ_PORT_NUM-1:0] i_rd_h_pri,
  input  logic [PADDR_W-1:0]       i_rd_paddr [READ_PORT_NUM],
  output logic [READ_PORT_NUM-1:0] o_rd_hit,
  output logic [READ_PORT_NUM-1:0] o_rd_miss,
  output logic [READ_PORT_NUM-1:0] o_rd_conflict,
  output logic [LINE_W-1:0]        o_rd_data [READ_PORT_NUM]
);

  paddr_u                   w_update_paddr;
  paddr_u                   w_rd_paddr [READ_PORT_NUM];
  paddr_u                   w_s0_rd_paddr;
  paddr_u                   w_s0_paddr;
  logic [READ_PORT_NUM-1:0] w_s0_grant_oh;
  logic [READ_PORT_NUM-1:0] w_s0_same_set;

  logic [READ_PORT_NUM-1:0] r_s1_rd_valid;
  logic [READ_PORT_NUM-1:0] r_s1_grant_oh;
  logic [READ_PORT_NUM-1:0] r_s1_same_set;
  logic                     r_s1_update_valid;

  logic [TAG_W-1:0]         w_s1_tag [WAYS];
  logic [WAYS-1:0]          w_s1_tag_valid;
  logic [LINE_W-1:0]        w_s1_data [WAYS];

  assign w_update_paddr.raw = i_update_paddr;

  dcache_port_arbiter #(
    .READ_PORT_NUM(READ_PORT_NUM)
  ) u_port_arbiter (
    .i_rd_valid(i_rd_valid),
    .i_rd_h_pri(i_rd_h_pri),
    .o_grant_oh(w_s0_grant_oh)
  );

  // or-select the granted port address with the one-hot grant
  always_comb begin
    w_s0_rd_paddr.raw = '0;
    for (int p = 0; p < READ_PORT_NUM; p++) begin
      if (w_s0_grant_oh[p]) begin
        w_s0_rd_paddr.raw |= w_rd_paddr[p].raw;
      end
    end
  end

  // an update takes the arrays for the whole cycle
  assign w_s0_paddr.raw = i_update_valid ? w_update_paddr.raw : w_s0_rd_paddr.raw;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_rd_valid     <= '0;
      r_s1_grant_oh     <= '0;
      r_s1_same_set     <= '0;
      r_s1_update_valid <= 1'b0;
    end else begin
      r_s1_rd_valid     <= i_rd_valid;
      r_s1_grant_oh     <= w_s0_grant_oh;
      r_s1_same_set     <= w_s0_same_set;
      r_s1_update_valid <= i_update_valid;
    end
  end

  for (genvar way = 0; way < WAYS; way++) begin : g_way
    logic w_way_wr;

    assign w_way_wr = i_update_valid && (i_update_way == WAY_W'(way));

    dcache_tag_array u_tag_array (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_wr       (w_way_wr),
      .i_index    (w_s0_paddr.f.index),
      .i_tag      (w_update_paddr.f.tag),
      .o_tag      (w_s1_tag[way]),
      .o_tag_valid(w_s1_tag_valid[way])
    );

    dcache_data_array u_data_array (
      .i_clk  (i_clk),
      .i_wr   (w_way_wr),
      .i_index(w_s0_paddr.f.index),
      .i_be   (i_update_be),
      .i_data (i_update_data),
      .o_data (w_s1_data[way])
    );
  end

  for (genvar p = 0; p < READ_PORT_NUM; p++) begin : g_port
    logic [TAG_W-1:0]  r_s1_tag;
    logic [WAYS-1:0]   w_s1_hit;
    logic [LINE_W-1:0] w_s1_line;
    logic              w_s1_req;

    assign w_rd_paddr[p].raw = i_rd_paddr[p];

    // ports on the winner's set share its lookup
    assign w_s0_same_set[p] = w_rd_paddr[p].f.index == w_s0_rd_paddr.f.index;

    always_ff @(posedge i_clk) begin
      r_s1_tag <= w_rd_paddr[p].f.tag;
    end

    for (genvar way = 0; way < WAYS; way++) begin : g_cmp
      assign w_s1_hit[way] = w_s1_tag_valid[way] && (w_s1_tag[way] == r_s1_tag);
    end

    always_comb begin
      w_s1_line = '0;
      for (int w = 0; w < WAYS; w++) begin
        if (w_s1_hit[w]) begin
          w_s1_line |= w_s1_data[w];
        end
      end
    end

    assign w_s1_req = !r_s1_update_valid && r_s1_rd_valid[p] &&
                      (r_s1_grant_oh[p] || r_s1_same_set[p]);

    assign o_rd_hit[p]      = w_s1_req && (|w_s1_hit);
    assign o_rd_miss[p]     = w_s1_req && !(|w_s1_hit);
    assign o_rd_conflict[p] = r_s1_rd_valid[p] &&
                              (r_s1_update_valid || (!r_s1_grant_oh[p] && !r_s1_same_set[p]));
    assign o_rd_data[p]     = w_s1_line;

    // a line lives in at most one way of a set
    a_hit_onehot: assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      w_s1_req |-> $onehot0(w_s1_hit)
    ) else $error("port %0d hit in more than one way", p);

    a_resp_excl: assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      $onehot0({o_rd_hit[p], o_rd_miss[p], o_rd_conflict[p]})
    ) else $error("port %0d hit, miss and conflict overlap", p);
  end

  a_update_way: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_update_valid |-> (int'(i_update_way) < WAYS)
  ) else $error("update way out of range");

endmodule

//--- hdl/dcache_data_array.sv
module dcache_data_array import dcache_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_wr,
  input  logic [INDEX_W-1:0]    i_index,
  input  logic [LINE_BYTES-1:0] i_be,
  input  logic [LINE_W-1:0]     i_data,
  output logic [LINE_W-1:0]     o_data
);

  localparam int SETS = 2 ** INDEX_W;

  logic [LINE_W-1:0]  mem_line [SETS];
  logic [INDEX_W-1:0] r_index;

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      // only enabled bytes change
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (i_be[b]) begin
          mem_line[i_index][b*8 +: 8] <= i_data[b*8 +: 8];
        end
      end
    end
    r_index <= i_index;
  end

  assign o_data = mem_line[r_index];

endmodule

//--- hdl/dcache_tag_array.sv
module dcache_tag_array import dcache_pkg::*; (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_wr,
  input  logic [INDEX_W-1:0] i_index,
  input  logic [TAG_W-1:0]   i_tag,
  output logic [TAG_W-1:0]   o_tag,
  output logic               o_tag_valid
);

  localparam int SETS = 2 ** INDEX_W;

  logic [TAG_W-1:0]   mem_tag [SETS];
  logic [SETS-1:0]    r_valid;
  logic [INDEX_W-1:0] r_index;

  // valid bits and read index
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_index <= '0;
    end else begin
      if (i_wr) begin
        r_valid[i_index] <= 1'b1;
      end
      r_index <= i_index;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      mem_tag[i_index] <= i_tag;
    end
  end

  // read through the latched index, so a write shows up next cycle
  assign o_tag       = mem_tag[r_index];
  assign o_tag_valid = r_valid[r_index];

endmodule

//--- hdl/dcache_port_arbiter.sv
module dcache_port_arbiter #(
  parameter int READ_PORT_NUM = 4
) (
  input  logic [READ_PORT_NUM-1:0] i_rd_valid,
  input  logic [READ_PORT_NUM-1:0] i_rd_h_pri,
  output logic [READ_PORT_NUM-1:0] o_grant_oh
);

  logic [READ_PORT_NUM-1:0] w_h_pri_req;
  logic [READ_PORT_NUM-1:0] w_h_pri_oh;
  logic [READ_PORT_NUM-1:0] w_norm_oh;

  // isolate the lowest set bit
  function automatic logic [READ_PORT_NUM-1:0] lowest_bit(
    input logic [READ_PORT_NUM-1:0] i_vec
  );
    return i_vec & (~i_vec + 1'b1);
  endfunction

  assign w_h_pri_req = i_rd_valid & i_rd_h_pri;
  assign w_h_pri_oh  = lowest_bit(w_h_pri_req);
  assign w_norm_oh   = lowest_bit(i_rd_valid);

  // high priority requests win before anything else
  assign o_grant_oh = (|w_h_pri_req) ? w_h_pri_oh : w_norm_oh;

  // checked once the inputs have settled
  always_comb begin
    a_grant_legal: assert final (
      $onehot0(o_grant_oh) && ((o_grant_oh & ~i_rd_valid) == '0)
    ) else $error("arbiter grant not one-hot or not a requesting port");
  end

endmodule

//--- hdl/dcache_pkg.sv
package dcache_pkg;

  // physical address split
  localparam int PADDR_W  = 32;
  localparam int OFFSET_W = 4;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = PADDR_W - INDEX_W - OFFSET_W;

  // one cache line
  localparam int LINE_W     = 128;
  localparam int LINE_BYTES = LINE_W / 8;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } paddr_fields_t;

  // same word seen raw or as tag/index/offset
  typedef union packed {
    logic [PADDR_W-1:0] raw;
    paddr_fields_t      f;
  } paddr_u;

endpackage
